// ==== filelist.f ====
+incdir+.
xoodoo_pkg.sv
cyclist_pkg.sv
xoodoo_round.sv
xoodoo_permute.sv
cyclist_state.sv
cyclist_ctrl.sv
xoodyak_hash_top.sv
tb_xoodyak_hash.sv

// ==== Bender.yml ====
package:
  name: xoodyak_hash

sources:
  - xoodoo_pkg.sv
  - cyclist_pkg.sv
  - xoodoo_round.sv
  - xoodoo_permute.sv
  - cyclist_state.sv
  - cyclist_ctrl.sv
  - xoodyak_hash_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_xoodyak_hash.sv

// ==== tb_cyclist_model.svh ====
// ----------------------------------------------------------
// Reference model of Xoodoo and the Cyclist hash rules
// Included in the testbench module body after its imports
// ----------------------------------------------------------

// Round constants, round r at bits 12*r, last round first
localparam logic [143:0] REF_RC = {
        12'h012, 12'h1A0, 12'h0F0, 12'h380,
        12'h02C, 12'h060, 12'h014, 12'h120,
        12'h0D0, 12'h3C0, 12'h038, 12'h058
};

// Model state and flags
logic [383:0] ref_state;
logic         ref_up;
logic         ref_first;

function automatic logic [31:0] rotate_lane(input logic [31:0] v, input int n);
        return (v << n) | (v >> (32 - n));
endfunction

// One round, lane (x, y) held at index x + 4*y
function automatic logic [383:0] one_round(input logic [383:0] s, input logic [11:0] rc);
        logic [31:0]  a [12];
        logic [31:0]  b [12];
        logic [31:0]  e [4];
        logic [31:0]  p;
        logic [383:0] r;

        for (int i = 0; i < 12; i++) begin
                a[i] = s[32*i +: 32];
        end
        // Theta, parity of the column one step toward lower x
        for (int x = 0; x < 4; x++) begin
                p    = a[(x + 3) % 4] ^ a[4 + (x + 3) % 4] ^ a[8 + (x + 3) % 4];
                e[x] = rotate_lane(p, 5) ^ rotate_lane(p, 14);
        end
        for (int i = 0; i < 12; i++) begin
                a[i] = a[i] ^ e[i % 4];
        end
        // Rho-west
        for (int x = 0; x < 4; x++) begin
                b[x]     = a[x];
                b[4 + x] = a[4 + (x + 3) % 4];
                b[8 + x] = rotate_lane(a[8 + x], 11);
        end
        // Iota at z = 0
        b[0] = b[0] ^ {20'h0, rc};
        // Chi over the three lanes of each column
        for (int i = 0; i < 12; i++) begin
                a[i] = b[i] ^ (~b[(i + 4) % 12] & b[(i + 8) % 12]);
        end
        // Rho-east
        for (int x = 0; x < 4; x++) begin
                b[x]     = a[x];
                b[4 + x] = rotate_lane(a[4 + x], 1);
                b[8 + x] = rotate_lane(a[8 + (x + 2) % 4], 8);
        end
        for (int i = 0; i < 12; i++) begin
                r[32*i +: 32] = b[i];
        end
        return r;
endfunction

function automatic logic [383:0] permute_state(input logic [383:0] s);
        for (int k = 0; k < 12; k++) begin
                s = one_round(s, REF_RC[12*k +: 12]);
        end
        return s;
endfunction

// Down step, pad right after the data, Cd in the last byte
function automatic logic [383:0] apply_down(input logic [383:0] s, input logic empty,
                                            input block_t blk, input logic [7:0] cd);
        if (empty) begin
                s[7:0] = s[7:0] ^ 8'h01;
        end else begin
                s[127:0]   = s[127:0] ^ blk;
                s[135:128] = s[135:128] ^ 8'h01;
        end
        s[383:376] = s[383:376] ^ cd;
        return s;
endfunction

// Same as reset and init
function automatic void clear_model();
        ref_state = '0;
        ref_up    = 1'b1;
        ref_first = 1'b1;
endfunction

function automatic void absorb_block(input block_t blk);
        if (!ref_up) begin
                ref_state = permute_state(ref_state);
        end
        ref_state = apply_down(ref_state, 1'b0, blk, ref_first ? 8'h01 : 8'h00);
        ref_up    = 1'b0;
        ref_first = 1'b0;
endfunction

function automatic digest_t squeeze_block();
        if (ref_up) begin
                ref_state = apply_down(ref_state, 1'b1, '0, 8'h00);
        end
        ref_state = permute_state(ref_state);
        ref_up    = 1'b1;
        return ref_state[127:0];
endfunction

// ==== tb_xoodyak_hash.sv ====
// ----------------------------------------------------------
// Testbench for the Xoodyak hash engine
// Applies a command table and checks digests, busy and done
// against the reference model
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_xoodyak_hash;
        import xoodoo_pkg::*;
        import cyclist_pkg::*;

        localparam int          ROUNDS_PER_CYCLE = 3;
        localparam int          PERM_CYCLES      = NUM_ROUNDS / ROUNDS_PER_CYCLE;
        localparam int          NUM_TESTS        = 15;
        localparam logic [31:0] LFSR_SEED        = 32'd41;
        localparam int          TIMEOUT_CYCLES   = 10 + NUM_TESTS * (PERM_CYCLES + 4) + 20;

        // One table row
        typedef struct packed {
                op_e    op;
                logic   use_lfsr;
                block_t block;
                logic   poke;
                logic   check;
        } entry_t;

        logic    eph1;
        logic    rst;
        logic    start;
        cmd_t    cmd;
        logic    busy;
        logic    done;
        digest_t digest;

        entry_t      tests [NUM_TESTS];
        logic [31:0] lfsr;
        int          cycle_count = 0;
        block_t      blk;
        digest_t     expected;

        `include "tb_cyclist_model.svh"

        xoodyak_hash_top #(
                .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
        ) DUT (
                .eph1   (eph1),
                .rst    (rst),
                .start  (start),
                .cmd    (cmd),
                .busy   (busy),
                .done   (done),
                .digest (digest)
        );

        always #5 eph1 = ~eph1;

        // Run length guard
        always @(posedge eph1) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("Simulation timed out after %0d cycles", cycle_count);
                        $display("Test failed");
                        $fatal(1);
                end
        end

        task automatic check_value(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
                if (got !== exp) begin
                        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
                        $display("Test failed");
                        $fatal(1);
                end
        endtask

        // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        // One LFSR step per block bit
        function automatic block_t random_block();
                block_t b;
                for (int i = 0; i < BLOCK_BYTES * 8; i++) begin
                        b[i] = lfsr[0];
                        lfsr = lfsr_next(lfsr);
                end
                return b;
        endfunction

        function automatic entry_t make_entry(input op_e op, input logic use_lfsr,
                                              input block_t block, input logic poke,
                                              input logic check);
                entry_t e;
                e.op       = op;
                e.use_lfsr = use_lfsr;
                e.block    = block;
                e.poke     = poke;
                e.check    = check;
                return e;
        endfunction

        // Starts at a falling edge with the DUT idle, ends one cycle after done
        task automatic run_command(input op_e op, input block_t b, input logic poke);
                cmd.op    = op;
                cmd.block = b;
                start     = 1'b1;
                @(negedge eph1);
                start = 1'b0;
                // Competing command while busy, must be ignored
                if (poke) begin
                        cmd.op    = (op == OP_INIT) ? OP_SQUEEZE : OP_INIT;
                        cmd.block = ~b;
                        start     = 1'b1;
                end
                while (!done) begin
                        check_value("busy", busy, 1);
                        @(negedge eph1);
                        start = 1'b0;
                end
                check_value("busy", busy, 0);
                @(negedge eph1);
                // Done is a single pulse
                check_value("done", done, 0);
                check_value("busy", busy, 0);
        endtask

        initial begin
                eph1  = 1'b0;
                rst   = 1'b1;
                start = 1'b0;
                cmd   = '0;
                lfsr  = LFSR_SEED;

                // op, LFSR block, fixed block, start while busy, check digest
                tests[0]  = make_entry(OP_SQUEEZE, 1'b0, '0, 1'b0, 1'b1);
                tests[1]  = make_entry(OP_INIT,    1'b0, '0, 1'b0, 1'b0);
                tests[2]  = make_entry(OP_ABSORB,  1'b1, '0, 1'b0, 1'b0);
                tests[3]  = make_entry(OP_SQUEEZE, 1'b0, '0, 1'b0, 1'b1);
                tests[4]  = make_entry(OP_INIT,    1'b0, '0, 1'b0, 1'b0);
                tests[5]  = make_entry(OP_ABSORB,  1'b1, '0, 1'b0, 1'b0);
                tests[6]  = make_entry(OP_ABSORB,  1'b0,
                                       128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff, 1'b1, 1'b0);
                tests[7]  = make_entry(OP_ABSORB,  1'b1, '0, 1'b0, 1'b0);
                tests[8]  = make_entry(OP_SQUEEZE, 1'b0, '0, 1'b0, 1'b1);
                tests[9]  = make_entry(OP_SQUEEZE, 1'b0, '0, 1'b1, 1'b1);
                tests[10] = make_entry(OP_SQUEEZE, 1'b0, '0, 1'b0, 1'b1);
                // Absorb from the up phase, then init mid-session
                tests[11] = make_entry(OP_ABSORB,  1'b1, '0, 1'b0, 1'b0);
                tests[12] = make_entry(OP_INIT,    1'b0, '0, 1'b1, 1'b0);
                tests[13] = make_entry(OP_ABSORB,  1'b1, '0, 1'b1, 1'b0);
                tests[14] = make_entry(OP_SQUEEZE, 1'b0, '0, 1'b0, 1'b1);

                clear_model();
                repeat (10) @(negedge eph1);
                rst = 1'b0;
                @(negedge eph1);
                check_value("busy", busy, 0);
                check_value("done", done, 0);
                check_value("digest", digest, 0);

                for (int i = 0; i < NUM_TESTS; i++) begin
                        if (tests[i].use_lfsr) begin
                                blk = random_block();
                        end else begin
                                blk = tests[i].block;
                        end
                        case (tests[i].op)
                                OP_INIT:   clear_model();
                                OP_ABSORB: absorb_block(blk);
                                default:   expected = squeeze_block();
                        endcase
                        run_command(tests[i].op, blk, tests[i].poke);
                        if (tests[i].check) begin
                                check_value("digest", digest, expected);
                        end
                end

                $display("Test passed");
                $finish;
        end

endmodule : tb_xoodyak_hash

`default_nettype wire

// ==== xoodyak_hash_top.sv ====
// ----------------------------------------------------------
// Xoodyak hash engine top level
// Pulse start with cmd while busy is low, wait for done,
// read digest after a squeeze
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module xoodyak_hash_top #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic                 eph1,
        input  logic                 rst,
        input  logic                 start,
        input  cyclist_pkg::cmd_t    cmd,
        output logic                 busy,
        output logic                 done,
        output cyclist_pkg::digest_t digest
);
        import xoodoo_pkg::*;
        import cyclist_pkg::*;

        // Control to datapath
        state_ctl_t state_ctl;
        logic       perm_start;
        logic       perm_done;

        // Permutation input and result
        state_t     state;
        state_t     perm_out;

        cyclist_ctrl u_ctrl (
                .eph1       (eph1),
                .rst        (rst),
                .start      (start),
                .cmd        (cmd),
                .perm_done  (perm_done),
                .state_ctl  (state_ctl),
                .perm_start (perm_start),
                .busy       (busy),
                .done       (done)
        );

        cyclist_state u_state (
                .eph1      (eph1),
                .rst       (rst),
                .state_ctl (state_ctl),
                .perm_out  (perm_out),
                .state     (state),
                .digest    (digest)
        );

        xoodoo_permute #(
                .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
        ) u_permute (
                .eph1       (eph1),
                .rst        (rst),
                .perm_start (perm_start),
                .state_in   (state),
                .perm_out   (perm_out),
                .perm_done  (perm_done)
        );

endmodule : xoodyak_hash_top

`default_nettype wire

// ==== cyclist_ctrl.sv ====
// ----------------------------------------------------------
// Hash-mode command FSM
// Accepts one command per start while idle, sequences the
// permutation and Down steps, pulses done at the end
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cyclist_ctrl (
        input  logic                    eph1,
        input  logic                    rst,
        input  logic                    start,
        input  cyclist_pkg::cmd_t       cmd,
        input  logic                    perm_done,
        output cyclist_pkg::state_ctl_t state_ctl,
        output logic                    perm_start,
        output logic                    busy,
        output logic                    done
);
        import cyclist_pkg::*;

        typedef enum logic [2:0] {
                IDLE,
                PRE_PERM,
                DOWN,
                PERM,
                FINISH
        } fsm_e;

        fsm_e fsm;
        fsm_e fsm_next;

        // Latched command
        cmd_t cmd_q;

        // Phase is down after an absorb
        logic phase_down;
        // Next absorb is the first since init
        logic first;

        logic accept;

        assign accept     = start && (fsm == IDLE);
        assign busy       = (fsm != IDLE);
        assign perm_start = (fsm == PRE_PERM);

        // ----------------------------------------------------------
        // Next state
        // ----------------------------------------------------------
        always_comb begin
                fsm_next = fsm;
                case (fsm)
                        IDLE: begin
                                if (accept) begin
                                        case (cmd.op)
                                                // Absorb after absorb permutes first
                                                OP_ABSORB:  fsm_next = phase_down ? PRE_PERM : DOWN;
                                                OP_SQUEEZE: fsm_next = PRE_PERM;
                                                default:    fsm_next = FINISH;
                                        endcase
                                end
                        end
                        PRE_PERM: fsm_next = PERM;
                        PERM: begin
                                if (perm_done) begin
                                        fsm_next = (cmd_q.op == OP_ABSORB) ? DOWN : FINISH;
                                end
                        end
                        DOWN:     fsm_next = IDLE;
                        FINISH:   fsm_next = IDLE;
                        default:  fsm_next = IDLE;
                endcase
        end

        // ----------------------------------------------------------
        // Datapath strobes
        // ----------------------------------------------------------
        always_comb begin
                state_ctl                = '0;
                state_ctl.clear_state    = (fsm == FINISH) && (cmd_q.op == OP_INIT);
                state_ctl.capture_digest = (fsm == FINISH) && (cmd_q.op == OP_SQUEEZE);
                state_ctl.load_perm      = (fsm == PERM) && perm_done;

                // Empty Down ahead of a squeeze from the up phase
                if ((fsm == PRE_PERM) && (cmd_q.op == OP_SQUEEZE) && !phase_down) begin
                        state_ctl.down.en    = 1'b1;
                        state_ctl.down.empty = 1'b1;
                end

                // Absorb injection with Cd on the first block only
                if (fsm == DOWN) begin
                        state_ctl.down.en    = 1'b1;
                        state_ctl.down.block = cmd_q.block;
                        state_ctl.down.cd    = first ? CD_FIRST_ABSORB : 8'h00;
                end
        end

        always_ff @(posedge eph1) begin
                if (accept) begin
                        cmd_q <= cmd;
                end
        end

        always_ff @(posedge eph1) begin
                if (rst) begin
                        fsm        <= IDLE;
                        done       <= 1'b0;
                        phase_down <= 1'b0;
                        first      <= 1'b1;
                end else begin
                        fsm  <= fsm_next;
                        // Last work cycle of every command
                        done <= (fsm == DOWN) || (fsm == FINISH);
                        if (fsm == DOWN) begin
                                phase_down <= 1'b1;
                                first      <= 1'b0;
                        end
                        if ((fsm == FINISH) && (cmd_q.op == OP_INIT)) begin
                                phase_down <= 1'b0;
                                first      <= 1'b1;
                        end
                        if ((fsm == FINISH) && (cmd_q.op == OP_SQUEEZE)) begin
                                phase_down <= 1'b0;
                        end
                end
        end

endmodule : cyclist_ctrl

`default_nettype wire

// ==== cyclist_state.sv ====
// ----------------------------------------------------------
// Cyclist state register and digest holder
// Driven by the command FSM through the state_ctl bundle
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module cyclist_state (
        input  logic                    eph1,
        input  logic                    rst,
        input  cyclist_pkg::state_ctl_t state_ctl,
        input  xoodoo_pkg::state_t      perm_out,
        output xoodoo_pkg::state_t      state,
        output cyclist_pkg::digest_t    digest
);
        import xoodoo_pkg::*;
        import cyclist_pkg::*;

        // Stored state, flat bytes
        logic [STATE_W-1:0] state_r;

        // XOR mask of the pending Down step
        logic [STATE_W-1:0] inj;

        // Flat view of the permutation result
        logic [STATE_W-1:0] perm_bits;

        assign perm_bits = perm_out;

        always_comb begin
                inj = '0;
                if (state_ctl.down.en) begin
                        if (state_ctl.down.empty) begin
                                // Pad only, at byte 0
                                inj[7:0] = PAD_BYTE;
                        end else begin
                                inj[BLOCK_BYTES*8-1:0]   = state_ctl.down.block;
                                inj[BLOCK_BYTES*8 +: 8] = PAD_BYTE;
                        end
                        // Cd goes in the last byte
                        inj[STATE_W-8 +: 8] = inj[STATE_W-8 +: 8] ^ state_ctl.down.cd;
                end
        end

        // Permute sees the Down folded in on the same cycle
        assign state = state_r ^ inj;

        // ----------------------------------------------------------
        // State update
        // ----------------------------------------------------------
        always_ff @(posedge eph1) begin
                if (rst) begin
                        state_r <= '0;
                end else if (state_ctl.clear_state) begin
                        state_r <= '0;
                end else if (state_ctl.load_perm) begin
                        state_r <= perm_bits;
                end else if (state_ctl.down.en) begin
                        state_r <= state;
                end
        end

        // Digest holds until the next squeeze
        always_ff @(posedge eph1) begin
                if (rst) begin
                        digest <= '0;
                end else if (state_ctl.capture_digest) begin
                        digest <= perm_bits[BLOCK_BYTES*8-1:0];
                end
        end

endmodule : cyclist_state

`default_nettype wire

// ==== xoodoo_permute.sv ====
// ----------------------------------------------------------
// Iterative Xoodoo permutation, several rounds per clock
// Pulse perm_start with state_in valid, result follows on
// perm_done exactly NUM_ROUNDS/ROUNDS_PER_CYCLE cycles later
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module xoodoo_permute #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic               eph1,
        input  logic               rst,
        input  logic               perm_start,
        input  xoodoo_pkg::state_t state_in,
        output xoodoo_pkg::state_t perm_out,
        output logic               perm_done
);
        import xoodoo_pkg::*;

        // Number of clocked groups
        localparam int NUM_GROUPS = NUM_ROUNDS / ROUNDS_PER_CYCLE;
        localparam int GRP_W      = (NUM_GROUPS > 1) ? $clog2(NUM_GROUPS) : 1;

        // Working state, payload only
        state_t work;

        // Group index and run flag
        logic [GRP_W-1:0] grp;
        logic [GRP_W-1:0] grp_sel;
        logic             active;

        // Round chain
        state_t stage [ROUNDS_PER_CYCLE+1];
        rc_t    rc    [ROUNDS_PER_CYCLE];

        // First group works straight from state_in
        assign stage[0] = perm_start ? state_in : work;
        assign grp_sel  = perm_start ? '0 : grp;

        for (genvar k = 0; k < ROUNDS_PER_CYCLE; k++) begin : g_round
                assign rc[k] = ROUND_CONSTANTS[int'(grp_sel) * ROUNDS_PER_CYCLE + k];

                xoodoo_round u_round (
                        .rc        (rc[k]),
                        .state_in  (stage[k]),
                        .state_out (stage[k+1])
                );
        end

        always_ff @(posedge eph1) begin
                if (perm_start || active) begin
                        work <= stage[ROUNDS_PER_CYCLE];
                end
        end

        // ----------------------------------------------------------
        // Group sequencing
        // ----------------------------------------------------------
        always_ff @(posedge eph1) begin
                if (rst) begin
                        grp       <= '0;
                        active    <= 1'b0;
                        perm_done <= 1'b0;
                end else if (perm_start) begin
                        grp       <= GRP_W'(1);
                        active    <= (NUM_GROUPS > 1);
                        perm_done <= (NUM_GROUPS == 1);
                end else if (active) begin
                        grp <= grp + 1'b1;
                        // Last group computed this cycle
                        if (grp == GRP_W'(NUM_GROUPS - 1)) begin
                                active    <= 1'b0;
                                perm_done <= 1'b1;
                        end
                end else begin
                        perm_done <= 1'b0;
                end
        end

        assign perm_out = work;

endmodule : xoodoo_permute

`default_nettype wire

// ==== xoodoo_round.sv ====
// ----------------------------------------------------------
// One combinational Xoodoo round
// Chained by the permutation engine, one copy per round
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module xoodoo_round (
        input  xoodoo_pkg::rc_t    rc,
        input  xoodoo_pkg::state_t state_in,
        output xoodoo_pkg::state_t state_out
);
        import xoodoo_pkg::*;

        // Barrel rotate toward higher z
        function automatic lane_t rotl(input lane_t a, input int n);
                return (a << n) | (a >> (LANE_W - n));
        endfunction

        // Column parity and its effect
        plane_t p;
        plane_t e;

        // Step outputs
        state_t theta;
        state_t rho_w;
        state_t chi;
        state_t rho_e;

        always_comb begin
                // Theta
                p = state_in[0] ^ state_in[1] ^ state_in[2];
                for (int x = 0; x < 4; x++) begin
                        // P shifted by (1,5) and (1,14)
                        e[x] = rotl(p[(x + 3) % 4], 5) ^ rotl(p[(x + 3) % 4], 14);
                end
                for (int y = 0; y < 3; y++) begin
                        theta[y] = state_in[y] ^ e;
                end

                // Rho-west, plane 1 moves one lane and plane 2 rotates by 11
                rho_w[0] = theta[0];
                for (int x = 0; x < 4; x++) begin
                        rho_w[1][x] = theta[1][(x + 3) % 4];
                        rho_w[2][x] = rotl(theta[2][x], 11);
                end

                // Iota on lane (0,0), constant LSB first at z = 0
                rho_w[0][0] = theta[0][0] ^ lane_t'(rc);

                // Chi
                chi[0] = rho_w[0] ^ (~rho_w[1] & rho_w[2]);
                chi[1] = rho_w[1] ^ (~rho_w[2] & rho_w[0]);
                chi[2] = rho_w[2] ^ (~rho_w[0] & rho_w[1]);

                // Rho-east
                rho_e[0] = chi[0];
                for (int x = 0; x < 4; x++) begin
                        rho_e[1][x] = rotl(chi[1][x], 1);
                        // Two lanes over plus z rotation of 8
                        rho_e[2][x] = rotl(chi[2][(x + 2) % 4], 8);
                end
        end

        assign state_out = rho_e;

endmodule : xoodoo_round

`default_nettype wire

// ==== cyclist_pkg.sv ====
// ----------------------------------------------------------
// Cyclist hash-mode command and control types
// Used by the command FSM, the state register and the top
// ----------------------------------------------------------

`default_nettype none

package cyclist_pkg;

        // Hash rate in bytes
        localparam int BLOCK_BYTES = 16;

        typedef logic [BLOCK_BYTES*8-1:0] block_t;
        typedef logic [BLOCK_BYTES*8-1:0] digest_t;

        // Hash-mode commands only
        typedef enum logic [1:0] {
                OP_INIT    = 2'd0,
                OP_ABSORB  = 2'd1,
                OP_SQUEEZE = 2'd2
        } op_e;

        // Command as presented on start
        typedef struct packed {
                op_e    op;
                block_t block;
        } cmd_t;

        // One Down step request
        typedef struct packed {
                logic       en;
                // Empty means no block, pad goes at byte 0
                logic       empty;
                block_t     block;
                logic [7:0] cd;
        } down_req_t;

        // Control bundle from the FSM to the state register
        typedef struct packed {
                down_req_t down;
                logic      clear_state;
                logic      load_perm;
                logic      capture_digest;
        } state_ctl_t;

        // Cd of the first absorb after init
        localparam logic [7:0] CD_FIRST_ABSORB = 8'h01;

        // Byte placed right after the absorbed data
        localparam logic [7:0] PAD_BYTE = 8'h01;

endpackage : cyclist_pkg

`default_nettype wire

// ==== xoodoo_pkg.sv ====
// ----------------------------------------------------------
// Xoodoo permutation types and constants
// Shared by the round logic, the iterative engine and the
// Cyclist state register
// ----------------------------------------------------------

`default_nettype none

package xoodoo_pkg;

        // ----------------------------------------------------------
        // Geometry
        // ----------------------------------------------------------

        // Full permutation width in bits
        localparam int STATE_W = 384;

        // One lane runs along z
        localparam int LANE_W = 32;

        // Rounds in one full permutation
        localparam int NUM_ROUNDS = 12;

        // Bit index inside the state is z + 32*(x + 4*y)
        typedef logic [LANE_W-1:0] lane_t;

        // Four lanes side by side, indexed by x
        typedef lane_t [3:0] plane_t;

        // Three planes, indexed plane, lane, z
        typedef plane_t [2:0] state_t;

        // ----------------------------------------------------------
        // Round constants
        // ----------------------------------------------------------

        typedef logic [11:0] rc_t;

        // Round order, LSB lands on z = 0 of plane 0 lane 0
        localparam rc_t ROUND_CONSTANTS [NUM_ROUNDS] = '{
                12'h058, 12'h038, 12'h3C0, 12'h0D0,
                12'h120, 12'h014, 12'h060, 12'h02C,
                12'h380, 12'h0F0, 12'h1A0, 12'h012
        };

endpackage : xoodoo_pkg

`default_nettype wire
